/* include/heap_params.svh */
/*
  Array heap sizes, APB widths and register map,
  with the field positions inside CMD and STATUS
*/
`ifndef HEAP_PARAMS_SVH
`define HEAP_PARAMS_SVH

`define HEAP_ARRAY_BITS      2   // Four arrays
`define HEAP_INDEX_BITS      2   // Four elements per array
`define HEAP_DATA_BITS       16  // Element width

`define HEAP_APB_ADDR_BITS   4
`define HEAP_APB_DATA_BITS   32

`define HEAP_REG_CMD         0   // Byte offsets on the APB side
`define HEAP_REG_DATA        4
`define HEAP_REG_RESULT      8
`define HEAP_REG_STATUS      12

`define HEAP_CMD_OP_LSB      0   // Opcode field of a CMD write
`define HEAP_CMD_ARRAY_LSB   8   // Array number field
`define HEAP_CMD_INDEX_LSB   16  // Element index field
`define HEAP_STATUS_BUSY_BIT 8   // Error code sits in the low bits

`endif

/* logic/heapPkg.sv */
/*
  Array heap types: widths of ids, indexes, sizes and elements,
  plus the opcode, error code and port state encodings
*/
`default_nettype none

`include "heap_params.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayIdT;    // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndexT;  // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   arraySizeT;  // Counts up to a full array
  typedef logic [`HEAP_DATA_BITS-1:0]  elemDataT;   // Element value

  typedef enum logic [3:0] {
    opNop   = 4'd0,
    opReset = 4'd1,   // Drop every array
    opAlloc = 4'd2,
    opFree  = 4'd3,
    opWrite = 4'd4,
    opRead  = 4'd5,
    opSize  = 4'd6,
    opPush  = 4'd7,
    opPop   = 4'd8,
    opAdd   = 4'd9,   // Arithmetic ops return the new value
    opSub   = 4'd10,
    opAnd   = 4'd11,
    opOr    = 4'd12,
    opXor   = 4'd13
  } heapOpT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,
    errOutOfBounds  = 3'd2,
    errFull         = 3'd3,
    errEmpty        = 3'd4,
    errOutOfMemory  = 3'd5
  } heapErrT;

  typedef enum logic [1:0] {
    stIdle,
    stEvaluate,
    stCommit
  } portStateT;

endpackage

`default_nettype wire

/* logic/heapCmdIf.sv */
/*
  Command bus between the APB port and the two heap engines.
  One command goes out, checks and element values come back
*/
`timescale 1ns/1ps
`default_nettype none

interface heapCmdIf;

  heapPkg::heapOpT    op;        // Held stable for the whole command
  heapPkg::arrayIdT   array;
  heapPkg::elemIndexT index;
  heapPkg::elemDataT  operand;   // DATA register contents
  logic               evaluate;  // One cycle, engines sample
  logic               commit;    // One cycle, only when error is none

  heapPkg::elemIndexT slot;      // Element actually addressed
  heapPkg::heapErrT   error;
  heapPkg::arraySizeT sizeOut;
  heapPkg::arrayIdT   allocId;
  heapPkg::elemDataT  value;

  modport port (output op, array, index, operand, evaluate, commit,
                input  error, sizeOut, allocId, value);

  modport directory (input  op, array, index, evaluate, commit,
                     output slot, error, sizeOut, allocId);

  modport store (input  op, array, slot, operand, evaluate, commit,
                 output value);

endinterface

`default_nettype wire

/* logic/arrayDirectory.sv */
/*
  Array directory: allocation flags, array sizes and the freed-array
  stack. Checks every command and maps it onto an element slot
*/
`timescale 1ns/1ps
`default_nettype none

`include "heap_params.svh"

module arrayDirectory (
  input wire                 clock,
  input wire                 resetN,
  heapCmdIf.directory        cmd
);

  localparam int ARRAYS = 2 ** `HEAP_ARRAY_BITS;
  localparam int LENGTH = 2 ** `HEAP_INDEX_BITS;

  logic [ARRAYS-1:0]         allocated;          // One flag per array
  heapPkg::arraySizeT        sizes [ARRAYS];
  heapPkg::arrayIdT          freeStack [ARRAYS]; // Most recent free on top
  logic [`HEAP_ARRAY_BITS:0] freeTop;            // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0] usedCount;          // Numbers handed out so far

  heapPkg::arraySizeT        curSize;
  heapPkg::arraySizeT        popSize;
  heapPkg::arraySizeT        wideIndex;
  heapPkg::arrayIdT          topIdx;
  heapPkg::arrayIdT          pick;
  heapPkg::heapErrT          check;
  logic                      onStack;

  assign curSize   = sizes[cmd.array];
  assign popSize   = curSize - 1'b1;
  assign wideIndex = {1'b0, cmd.index};
  assign topIdx    = freeTop[`HEAP_ARRAY_BITS-1:0] - 1'b1;
  assign pick      = (freeTop != '0) ? freeStack[topIdx]
                                     : usedCount[`HEAP_ARRAY_BITS-1:0];  // Reuse first

  always_comb begin
    case (cmd.op)
      heapPkg::opPush: cmd.slot = curSize[`HEAP_INDEX_BITS-1:0];  // One past the end
      heapPkg::opPop:  cmd.slot = popSize[`HEAP_INDEX_BITS-1:0];  // Last element
      default:         cmd.slot = cmd.index;
    endcase
  end

  // ------------------------------
  // Legality checks
  // ------------------------------
  always_comb begin
    check = heapPkg::errNone;
    if (cmd.op == heapPkg::opAlloc) begin
      if (freeTop == '0 && usedCount == ARRAYS) check = heapPkg::errOutOfMemory;
    end else if (cmd.op != heapPkg::opNop && cmd.op != heapPkg::opReset) begin
      if (!allocated[cmd.array]) begin
        check = heapPkg::errNotAllocated;  // Free of a free array lands here too
      end else if (cmd.op == heapPkg::opPush) begin
        if (curSize == LENGTH) check = heapPkg::errFull;
      end else if (cmd.op == heapPkg::opPop) begin
        if (curSize == '0) check = heapPkg::errEmpty;
      end else if (cmd.op inside {heapPkg::opRead, heapPkg::opAdd, heapPkg::opSub,
                                  heapPkg::opAnd, heapPkg::opOr, heapPkg::opXor}) begin
        if (wideIndex >= curSize) check = heapPkg::errOutOfBounds;
      end
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      cmd.error <= heapPkg::errNone;
    end else if (cmd.evaluate) begin
      cmd.error <= check;
    end
  end

  always_ff @(posedge clock) begin
    if (cmd.evaluate) begin
      cmd.sizeOut <= curSize;
      cmd.allocId <= pick;
    end
  end

  // ------------------------------
  // Commit
  // ------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      freeTop   <= '0;
      usedCount <= '0;
      for (int i = 0; i < ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else if (cmd.commit) begin
      case (cmd.op)
        heapPkg::opReset: begin
          allocated <= '0;
          freeTop   <= '0;           // Stale stack entries are ignored
          usedCount <= '0;
        end
        heapPkg::opAlloc: begin
          allocated[cmd.allocId] <= 1'b1;
          sizes[cmd.allocId]     <= '0;  // New arrays start empty
          if (freeTop != '0) freeTop <= freeTop - 1'b1;
          else usedCount <= usedCount + 1'b1;
        end
        heapPkg::opFree: begin
          allocated[cmd.array] <= 1'b0;
          freeTop              <= freeTop + 1'b1;
        end
        heapPkg::opWrite: begin
          if (wideIndex >= curSize) sizes[cmd.array] <= wideIndex + 1'b1;  // Grow
        end
        heapPkg::opPush: sizes[cmd.array] <= curSize + 1'b1;
        heapPkg::opPop:  sizes[cmd.array] <= popSize;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (cmd.commit && cmd.op == heapPkg::opFree) begin
      freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= cmd.array;
    end
  end

  always_comb begin
    onStack = 1'b0;
    for (int i = 0; i < ARRAYS; i++) begin
      if (i < freeTop && freeStack[i] == cmd.array) onStack = 1'b1;
    end
  end

  // Flags and stack must agree, so an array is never pushed twice
  assert property (@(posedge clock) disable iff (!resetN)
    cmd.commit && cmd.op == heapPkg::opFree |-> !onStack);

endmodule

`default_nettype wire

/* logic/elementStore.sv */
/*
  Element store: one fixed block of elements per array,
  plus the element arithmetic for the update commands
*/
`timescale 1ns/1ps
`default_nettype none

`include "heap_params.svh"

module elementStore (
  input wire      clock,
  heapCmdIf.store cmd
);

  localparam int ARRAYS = 2 ** `HEAP_ARRAY_BITS;
  localparam int LENGTH = 2 ** `HEAP_INDEX_BITS;

  heapPkg::elemDataT mem [ARRAYS][LENGTH];  // Array blocks
  heapPkg::elemDataT current;               // Element at array and slot
  heapPkg::elemDataT computed;
  heapPkg::elemDataT oldElem;
  heapPkg::elemDataT newElem;
  logic              writesElem;
  logic              memWrite;

  assign current = mem[cmd.array][cmd.slot];

  // ------------------------------
  // New element value
  // ------------------------------
  always_comb begin
    case (cmd.op)
      heapPkg::opWrite,
      heapPkg::opPush: computed = cmd.operand;
      heapPkg::opAdd:  computed = current + cmd.operand;  // Wraps to element width
      heapPkg::opSub:  computed = current - cmd.operand;
      heapPkg::opAnd:  computed = current & cmd.operand;
      heapPkg::opOr:   computed = current | cmd.operand;
      heapPkg::opXor:  computed = current ^ cmd.operand;
      default:         computed = current;
    endcase
  end

  assign writesElem = cmd.op inside {heapPkg::opWrite, heapPkg::opPush,
                                     heapPkg::opAdd, heapPkg::opSub,
                                     heapPkg::opAnd, heapPkg::opOr, heapPkg::opXor};
  assign memWrite   = cmd.commit && writesElem;

  always_ff @(posedge clock) begin
    if (cmd.evaluate) begin
      oldElem <= current;   // Read and pop return this
      newElem <= computed;
    end
    if (memWrite) begin
      mem[cmd.array][cmd.slot] <= newElem;  // Slot is unchanged since evaluate
    end
  end

  always_comb begin
    if (cmd.op == heapPkg::opRead || cmd.op == heapPkg::opPop) begin
      cmd.value = oldElem;
    end else begin
      cmd.value = newElem;
    end
  end

  // Memory only changes right after the element was sampled
  assert property (@(posedge clock) memWrite |-> $past(cmd.evaluate));

endmodule

`default_nettype wire

/* logic/heapApbPort.sv */
/*
  APB front end of the array heap. Holds DATA, RESULT and STATUS,
  starts a command on a CMD write and steps it through evaluate and commit
*/
`timescale 1ns/1ps
`default_nettype none

`include "heap_params.svh"

module heapApbPort (
  input wire                           clock,
  input wire                           resetN,
  input wire [`HEAP_APB_ADDR_BITS-1:0] paddr,
  input wire                           psel,
  input wire                           penable,
  input wire                           pwrite,
  input wire [`HEAP_APB_DATA_BITS-1:0] pwdata,
  output logic [`HEAP_APB_DATA_BITS-1:0] prdata,
  output logic                         pready,
  output logic                         pslverr,
  heapCmdIf.port                       cmd
);

  heapPkg::portStateT state;
  heapPkg::heapOpT    opReg;
  heapPkg::arrayIdT   arrayReg;
  heapPkg::elemIndexT indexReg;
  heapPkg::elemDataT  dataReg;
  heapPkg::elemDataT  resultReg;
  heapPkg::elemDataT  merged;
  heapPkg::heapErrT   statusErr;

  logic [$bits(heapPkg::heapOpT)-1:0] opField;
  logic busy;
  logic knownAddr;
  logic cmdStart;
  logic dataWrite;

  // ------------------------------
  // APB decode
  // ------------------------------
  assign busy      = state != heapPkg::stIdle;
  assign pready    = psel && penable && !busy;  // Only back-pressure
  assign knownAddr = paddr == `HEAP_REG_CMD || paddr == `HEAP_REG_DATA ||
                     paddr == `HEAP_REG_RESULT || paddr == `HEAP_REG_STATUS;
  assign pslverr   = pready && !knownAddr;
  assign cmdStart  = pready && pwrite && paddr == `HEAP_REG_CMD;
  assign dataWrite = pready && pwrite && paddr == `HEAP_REG_DATA;
  assign opField   = pwdata[`HEAP_CMD_OP_LSB +: $bits(heapPkg::heapOpT)];

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        `HEAP_REG_RESULT: prdata = `HEAP_APB_DATA_BITS'(resultReg);
        `HEAP_REG_STATUS: begin
          prdata[$bits(heapPkg::heapErrT)-1:0] = statusErr;
          prdata[`HEAP_STATUS_BUSY_BIT]        = busy;
        end
        default: prdata = '0;   // DATA is write-only
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (dataWrite) dataReg <= pwdata[`HEAP_DATA_BITS-1:0];
    if (cmdStart) begin
      arrayReg <= pwdata[`HEAP_CMD_ARRAY_LSB +: `HEAP_ARRAY_BITS];
      indexReg <= pwdata[`HEAP_CMD_INDEX_LSB +: `HEAP_INDEX_BITS];
    end
  end

  // ------------------------------
  // Result merge
  // ------------------------------
  always_comb begin
    case (opReg)
      heapPkg::opAlloc: merged = heapPkg::elemDataT'(cmd.allocId);
      heapPkg::opSize:  merged = heapPkg::elemDataT'(cmd.sizeOut);
      heapPkg::opFree,
      heapPkg::opReset: merged = '0;
      heapPkg::opNop:   merged = resultReg;
      default:          merged = cmd.value;  // Element ops come from the store
    endcase
  end

  // Command sequencer
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state     <= heapPkg::stIdle;
      opReg     <= heapPkg::opNop;
      resultReg <= '0;
      statusErr <= heapPkg::errNone;
    end else begin
      case (state)
        heapPkg::stIdle: begin
          if (cmdStart) begin
            state <= heapPkg::stEvaluate;
            opReg <= (opField <= heapPkg::opXor) ? heapPkg::heapOpT'(opField)
                                                 : heapPkg::opNop;  // Unknown codes do nothing
          end
        end
        heapPkg::stEvaluate: state <= heapPkg::stCommit;
        default: begin
          state     <= heapPkg::stIdle;
          statusErr <= cmd.error;  // Readable as soon as busy drops
          if (cmd.error == heapPkg::errNone) resultReg <= merged;
        end
      endcase
    end
  end

  assign cmd.op       = opReg;
  assign cmd.array    = arrayReg;
  assign cmd.index    = indexReg;
  assign cmd.operand  = dataReg;
  assign cmd.evaluate = state == heapPkg::stEvaluate;
  assign cmd.commit   = state == heapPkg::stCommit && cmd.error == heapPkg::errNone;

  assert property (@(posedge clock) disable iff (!resetN)
    cmd.commit |-> $past(cmd.evaluate));

  // No transfer completes in the two cycles after a CMD write
  assert property (@(posedge clock) disable iff (!resetN)
    $past(cmdStart) || $past(cmdStart, 2) |-> !pready);

endmodule

`default_nettype wire

/* logic/arrayHeap.sv */
/*
  Array heap top level: APB slave port in front of
  the array directory and the element store
*/
`timescale 1ns/1ps
`default_nettype none

`include "heap_params.svh"

module arrayHeap (
  input wire                            clock,
  input wire                            resetN,
  input wire [`HEAP_APB_ADDR_BITS-1:0]  paddr,
  input wire                            psel,
  input wire                            penable,
  input wire                            pwrite,
  input wire [`HEAP_APB_DATA_BITS-1:0]  pwdata,
  output wire [`HEAP_APB_DATA_BITS-1:0] prdata,
  output wire                           pready,
  output wire                           pslverr
);

  heapCmdIf cmdBus ();  // Shared command and result bus

  heapApbPort apbPort (
    .clock   (clock),
    .resetN  (resetN),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cmd     (cmdBus.port)
  );

  arrayDirectory directory (
    .clock  (clock),
    .resetN (resetN),
    .cmd    (cmdBus.directory)
  );

  elementStore store (
    .clock (clock),
    .cmd   (cmdBus.store)
  );

endmodule

`default_nettype wire

/* testbench/heapScoreboard.sv */
/*
  Array heap scoreboard: keeps a model of the heap, follows every
  APB transfer and compares RESULT, STATUS, pready and pslverr with it
*/
`timescale 1ns/1ps
`default_nettype none

`include "heap_params.svh"

module heapScoreboard (
  input wire                           clock,
  input wire                           resetN,
  input wire [`HEAP_APB_ADDR_BITS-1:0] paddr,
  input wire                           psel,
  input wire                           penable,
  input wire                           pwrite,
  input wire [`HEAP_APB_DATA_BITS-1:0] pwdata,
  input wire [`HEAP_APB_DATA_BITS-1:0] prdata,
  input wire                           pready,
  input wire                           pslverr,
  output int                           checkCount,
  output int                           errorCount
);

  localparam int ARRAYS      = 2 ** `HEAP_ARRAY_BITS;
  localparam int LENGTH      = 2 ** `HEAP_INDEX_BITS;
  localparam int BUSY_CYCLES = 2;   // Evaluate and commit

  logic              allocated [ARRAYS];
  int                sizes [ARRAYS];
  heapPkg::elemDataT elems [ARRAYS][LENGTH];
  logic              known [ARRAYS][LENGTH];  // Written since the array was allocated
  int                freeStack [$];           // Back is the latest free
  int                usedCount;
  int                busyLeft;                // Cycles until the port is idle
  heapPkg::elemDataT operand;
  heapPkg::elemDataT expResult;
  heapPkg::heapErrT  expErr;
  logic              resultKnown;
  logic              badAddr;
  int                checks = 0;
  int                errors = 0;

  assign checkCount = checks;
  assign errorCount = errors;

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic clearModel();
    for (int a = 0; a < ARRAYS; a++) begin
      allocated[a] = 1'b0;
      sizes[a]     = 0;
      for (int i = 0; i < LENGTH; i++) begin
        known[a][i] = 1'b0;
      end
    end
    freeStack.delete();
    usedCount   = 0;
    busyLeft    = 0;
    operand     = '0;
    expResult   = '0;              // RESULT and STATUS read zero
    expErr      = heapPkg::errNone;
    resultKnown = 1'b1;
  endtask

  function automatic heapPkg::heapErrT checkCommand(input heapPkg::heapOpT op,
                                                    input int a, input int i);
    if (op == heapPkg::opAlloc) begin
      if (freeStack.size() == 0 && usedCount == ARRAYS) return heapPkg::errOutOfMemory;
    end else if (op != heapPkg::opReset && op != heapPkg::opNop) begin
      if (!allocated[a]) return heapPkg::errNotAllocated;
      if (op == heapPkg::opPush && sizes[a] == LENGTH) return heapPkg::errFull;
      if (op == heapPkg::opPop && sizes[a] == 0) return heapPkg::errEmpty;
      if ((op == heapPkg::opRead || op >= heapPkg::opAdd) && i >= sizes[a]) begin
        return heapPkg::errOutOfBounds;  // Element ops stay inside the size
      end
    end
    return heapPkg::errNone;
  endfunction

  // ------------------------------
  // Heap model
  // ------------------------------
  task automatic applyCommand(input logic [31:0] word);
    heapPkg::heapOpT   op;
    heapPkg::elemDataT res;
    int                a;
    int                i;
    int                id;
    logic              resKnown;
    op       = heapPkg::heapOpT'(word[`HEAP_CMD_OP_LSB +: 4]);
    a        = int'(word[`HEAP_CMD_ARRAY_LSB +: `HEAP_ARRAY_BITS]);
    i        = int'(word[`HEAP_CMD_INDEX_LSB +: `HEAP_INDEX_BITS]);
    res      = '0;
    resKnown = 1'b1;
    expErr   = checkCommand(op, a, i);
    if (expErr != heapPkg::errNone) return;  // Heap and RESULT stay as they were
    case (op)
      heapPkg::opReset: begin
        for (int k = 0; k < ARRAYS; k++) begin
          allocated[k] = 1'b0;
        end
        freeStack.delete();
        usedCount = 0;
      end
      heapPkg::opAlloc: begin
        if (freeStack.size() != 0) begin
          id = freeStack.pop_back();  // Latest free first
        end else begin
          id = usedCount;
          usedCount++;
        end
        allocated[id] = 1'b1;
        sizes[id]     = 0;
        for (int k = 0; k < LENGTH; k++) begin
          known[id][k] = 1'b0;
        end
        res = heapPkg::elemDataT'(id);
      end
      heapPkg::opFree: begin
        allocated[a] = 1'b0;
        freeStack.push_back(a);
      end
      heapPkg::opWrite: begin
        elems[a][i] = operand;
        known[a][i] = 1'b1;
        if (i >= sizes[a]) sizes[a] = i + 1;  // Grows the array
        res = operand;
      end
      heapPkg::opRead: begin
        res      = elems[a][i];
        resKnown = known[a][i];
      end
      heapPkg::opSize: res = heapPkg::elemDataT'(sizes[a]);
      heapPkg::opPush: begin
        elems[a][sizes[a]] = operand;
        known[a][sizes[a]] = 1'b1;
        sizes[a]++;
        res = operand;
      end
      heapPkg::opPop: begin
        sizes[a]--;
        res      = elems[a][sizes[a]];
        resKnown = known[a][sizes[a]];
      end
      heapPkg::opNop: begin
        res      = expResult;
        resKnown = resultKnown;
      end
      default: begin
        case (op)
          heapPkg::opAdd: res = elems[a][i] + operand;  // Wraps at element width
          heapPkg::opSub: res = elems[a][i] - operand;
          heapPkg::opAnd: res = elems[a][i] & operand;
          heapPkg::opOr:  res = elems[a][i] | operand;
          default:        res = elems[a][i] ^ operand;
        endcase
        elems[a][i] = res;
        resKnown    = known[a][i];
      end
    endcase
    expResult   = res;
    resultKnown = resKnown;
  endtask

  // ------------------------------
  // Transfer monitor
  // ------------------------------
  always @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      clearModel();
    end else begin
      if (psel && penable) begin
        compareValue("pready", 32'(busyLeft == 0), 32'(pready));  // Held only while busy
      end
      if (busyLeft > 0) busyLeft--;
      if (psel && penable && pready) begin
        badAddr = !(paddr inside {`HEAP_REG_CMD, `HEAP_REG_DATA,
                                  `HEAP_REG_RESULT, `HEAP_REG_STATUS});
        compareValue("pslverr", 32'(badAddr), 32'(pslverr));
        if (pwrite && paddr == `HEAP_REG_DATA) begin
          operand = pwdata[`HEAP_DATA_BITS-1:0];
        end else if (pwrite && paddr == `HEAP_REG_CMD) begin
          applyCommand(pwdata);
          busyLeft = BUSY_CYCLES;
        end else if (!pwrite && paddr == `HEAP_REG_RESULT) begin
          if (resultKnown) compareValue("RESULT", 32'(expResult), prdata);
        end else if (!pwrite && paddr == `HEAP_REG_STATUS) begin
          compareValue("STATUS", 32'(expErr), prdata);  // Busy is always clear here
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/arrayHeapTb.sv */
/*
  Array heap testbench: APB driver, a directed opening and
  seeded random commands, checked by the scoreboard
*/
`timescale 1ns/1ps
`default_nettype none

`include "heap_params.svh"

module arrayHeapTb;

  localparam int PERIOD     = 20;
  localparam int SEED       = 36;
  localparam int COMMANDS   = 400;
  localparam int DIRECTED   = 40;   // Bound on the opening sequence
  localparam int CMD_CYCLES = 10;   // Four transfers plus the busy wait
  localparam int ARRAYS     = 2 ** `HEAP_ARRAY_BITS;
  localparam int LENGTH     = 2 ** `HEAP_INDEX_BITS;

  logic                           clock = 1'b0;
  logic                           resetN;
  logic [`HEAP_APB_ADDR_BITS-1:0] paddr;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [`HEAP_APB_DATA_BITS-1:0] pwdata;
  wire  [`HEAP_APB_DATA_BITS-1:0] prdata;
  wire                            pready;
  wire                            pslverr;
  int                             checkCount;
  int                             errorCount;

  always #(PERIOD / 2) clock = ~clock;

  arrayHeap arrayHeap_inst (
    .clock   (clock),
    .resetN  (resetN),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  heapScoreboard scoreboard (
    .clock      (clock),
    .resetN     (resetN),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .checkCount (checkCount),
    .errorCount (errorCount)
  );

  // ------------------------------
  // APB driver
  // ------------------------------
  task automatic accessRegister(input logic write, input logic [`HEAP_APB_ADDR_BITS-1:0] addr,
                                input logic [`HEAP_APB_DATA_BITS-1:0] data);
    @(negedge clock);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge clock);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge clock);
      #1;
    end
    @(posedge clock);  // Transfer completes here
  endtask

  task automatic runCommand(input heapPkg::heapOpT op, input heapPkg::arrayIdT arr,
                            input heapPkg::elemIndexT idx, input heapPkg::elemDataT data);
    logic [31:0] word;
    word = 32'(op) << `HEAP_CMD_OP_LSB;
    word = word | (32'(arr) << `HEAP_CMD_ARRAY_LSB);
    word = word | (32'(idx) << `HEAP_CMD_INDEX_LSB);
    accessRegister(1'b1, `HEAP_REG_DATA, 32'(data));
    accessRegister(1'b1, `HEAP_REG_CMD, word);
    accessRegister(1'b0, `HEAP_REG_STATUS, '0);  // Held until the command ends
    accessRegister(1'b0, `HEAP_REG_RESULT, '0);
  endtask

  task automatic runDirected();
    accessRegister(1'b0, `HEAP_REG_RESULT, '0);  // Both zero after reset
    accessRegister(1'b0, `HEAP_REG_STATUS, '0);
    runCommand(heapPkg::opReset, 0, 0, 0);
    repeat (ARRAYS + 1) runCommand(heapPkg::opAlloc, 0, 0, 0);  // Last one runs out
    for (int k = 0; k <= LENGTH; k++) runCommand(heapPkg::opPush, 0, 0, 16'h0100 + k);
    repeat (LENGTH + 1) runCommand(heapPkg::opPop, 0, 0, 0);     // Reverse, then empty
    runCommand(heapPkg::opWrite, 1, 2, 16'hfff0);
    runCommand(heapPkg::opSize, 1, 0, 0);
    runCommand(heapPkg::opRead, 1, 3, 0);  // Beyond the size
    for (int k = 0; k < 5; k++) begin
      runCommand(heapPkg::heapOpT'(heapPkg::opAdd + k), 1, 2, 16'h0033);
    end
    runCommand(heapPkg::opRead, 1, 2, 0);
    runCommand(heapPkg::opFree, 2, 0, 0);
    runCommand(heapPkg::opFree, 2, 0, 0);  // Already free
    runCommand(heapPkg::opAlloc, 0, 0, 0);
    runCommand(heapPkg::opSize, 2, 0, 0);
    accessRegister(1'b0, 4'd2, '0);        // Unused addresses
    accessRegister(1'b1, 4'd14, 32'h1);
  endtask

  task automatic runRandom();
    int              roll;
    heapPkg::heapOpT op;
    roll = $urandom_range(99);
    if (roll < 8) op = heapPkg::opAlloc;
    else if (roll < 13) op = heapPkg::opFree;
    else if (roll < 33) op = heapPkg::opWrite;
    else if (roll < 48) op = heapPkg::opRead;
    else if (roll < 53) op = heapPkg::opSize;
    else if (roll < 65) op = heapPkg::opPush;
    else if (roll < 77) op = heapPkg::opPop;
    else if (roll < 98) op = heapPkg::heapOpT'(heapPkg::opAdd + roll % 5);
    else op = heapPkg::opReset;
    runCommand(op, heapPkg::arrayIdT'($urandom_range(ARRAYS - 1)),
               heapPkg::elemIndexT'($urandom_range(LENGTH - 1)),
               heapPkg::elemDataT'($urandom));
  endtask

  initial begin
    void'($urandom(SEED));
    resetN  = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    runDirected();
    for (int n = 0; n < COMMANDS; n++) runRandom();
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
    @(negedge clock);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the command count
  initial begin
    #((COMMANDS + DIRECTED) * CMD_CYCLES * PERIOD);
    $display("Timeout: the commands did not finish within the time limit");
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
logic/heapPkg.sv
logic/heapCmdIf.sv
logic/arrayDirectory.sv
logic/elementStore.sv
logic/heapApbPort.sv
logic/arrayHeap.sv
testbench/heapScoreboard.sv
testbench/arrayHeapTb.sv

/* build.sh */
#!/usr/bin/env bash
# Builds the array heap testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_NAME=arrayHeapSim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module arrayHeapTb -f verilog.f -Mdir "$BUILD_DIR" -o "$SIM_NAME"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_NAME" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG_FILE"; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation passed"
exit 0
